//--- verilog/rp_cfg.svh
/*
  Front end configuration: widths, channel counts,
  bus address map and identification value
*/
`ifndef RP_CFG_SVH
`define RP_CFG_SVH

// Sample widths and channel counts
`define RP_ADC_DW   16
`define RP_DAC_DW   14
`define RP_CHN      2
`define RP_PDM_CHN  4
`define RP_PDM_DW   8
`define RP_PDM_RNG  255

// System bus geometry
`define RP_BUS_AW   8
`define RP_BUS_DW   32

// Identification word, reads as "RPIT"
`define RP_ID       32'h52504954

// Region 0 word addresses
`define RP_REG_ID   8'd0
`define RP_REG_CTL  8'd1
`define RP_REG_DAC0 8'd2
`define RP_REG_DAC1 8'd3
`define RP_REG_ADC0 8'd4
`define RP_REG_ADC1 8'd5

// Region 1 word address
`define RP_REG_PDM  8'd0

`endif

//--- verilog/rp_bus_pkg.sv
/*
  System bus types: address, data and region select
*/
`default_nettype none

`include "rp_cfg.svh"

package rp_bus_pkg;

  // Bus address and data words
  typedef logic [`RP_BUS_AW-1:0] bus_addr_t;
  typedef logic [`RP_BUS_DW-1:0] bus_data_t;

  // Region picked by top address bit
  typedef enum logic {
    REGION_SYS = 1'b0,
    REGION_PDM = 1'b1
  } region_t;

endpackage : rp_bus_pkg

`default_nettype wire

//--- verilog/rp_sample_pkg.sv
/*
  Sample types for ADC, DAC and PDM paths,
  plus the PDM configuration word
*/
`default_nettype none

`include "rp_cfg.svh"

package rp_sample_pkg;

  // Converted samples, two's complement
  typedef logic signed [`RP_ADC_DW-1:0] adc_sample_t;
  typedef logic signed [`RP_DAC_DW-1:0] dac_sample_t;

  // PDM duty level, 0 to full scale
  typedef logic [`RP_PDM_DW-1:0] pdm_level_t;

  // Same word seen by the bus or per channel
  // Channel 0 in the low byte
  typedef union packed {
    rp_bus_pkg::bus_data_t               raw;
    pdm_level_t [`RP_PDM_CHN-1:0]        lvl;
  } pdm_word_u;

endpackage : rp_sample_pkg

`default_nettype wire

//--- verilog/sys_bus_if.sv
/*
  One system bus region: strobes and write data from the decoder,
  read data and ack from the register block
*/
`default_nettype none

interface sys_bus_if;

  // Request side
  rp_bus_pkg::bus_addr_t addr;
  rp_bus_pkg::bus_data_t wdata;
  logic                  wen;
  logic                  ren;

  // Response side
  rp_bus_pkg::bus_data_t rdata;
  logic                  ack;

  // Decoder end
  modport master (output addr, wdata, wen, ren, input rdata, ack);

  // Register block end
  modport slave (input addr, wdata, wen, ren, output rdata, ack);

endinterface : sys_bus_if

`default_nettype wire

//--- verilog/sys_bus_decoder.sv
/*
  Bus decoder: steers strobes to one of two regions by the top
  address bit and returns that region's read data and ack
*/
`default_nettype none

`include "rp_cfg.svh"

module sys_bus_decoder (
  input  logic                  adc_clk_i,
  input  logic                  top_rst_i,
  input  rp_bus_pkg::bus_addr_t bus_addr_i,
  input  rp_bus_pkg::bus_data_t bus_wdata_i,
  input  logic                  bus_wen_i,
  input  logic                  bus_ren_i,
  output rp_bus_pkg::bus_data_t bus_rdata_o,
  output logic                  bus_ack_o,
  sys_bus_if.master             sys_bus_o,
  sys_bus_if.master             pdm_bus_o
);

  rp_bus_pkg::region_t sel;
  rp_bus_pkg::region_t pend;

  // Region from top bit
  assign sel = rp_bus_pkg::region_t'(bus_addr_i[`RP_BUS_AW-1]);

  // Region address drops the select bit
  assign sys_bus_o.addr  = {1'b0, bus_addr_i[`RP_BUS_AW-2:0]};
  assign pdm_bus_o.addr  = {1'b0, bus_addr_i[`RP_BUS_AW-2:0]};
  assign sys_bus_o.wdata = bus_wdata_i;
  assign pdm_bus_o.wdata = bus_wdata_i;

  // Strobes reach the selected region only
  assign sys_bus_o.wen = bus_wen_i & (sel == rp_bus_pkg::REGION_SYS);
  assign sys_bus_o.ren = bus_ren_i & (sel == rp_bus_pkg::REGION_SYS);
  assign pdm_bus_o.wen = bus_wen_i & (sel == rp_bus_pkg::REGION_PDM);
  assign pdm_bus_o.ren = bus_ren_i & (sel == rp_bus_pkg::REGION_PDM);

  // Remember who owes the answer
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      pend <= rp_bus_pkg::REGION_SYS;
    end else if (bus_wen_i || bus_ren_i) begin
      pend <= sel;
    end
  end

  // Response mux
  assign bus_rdata_o = (pend == rp_bus_pkg::REGION_PDM) ? pdm_bus_o.rdata : sys_bus_o.rdata;
  assign bus_ack_o   = sys_bus_o.ack | pdm_bus_o.ack;

  // Only one region may answer at a time
  a_one_ack : assert property (@(posedge adc_clk_i) disable iff (top_rst_i)
    !(sys_bus_o.ack && pdm_bus_o.ack));

endmodule : sys_bus_decoder

`default_nettype wire

//--- verilog/sys_regs.sv
/*
  Region 0 registers: ID, control, DAC levels and ADC readback
*/
`default_nettype none

`include "rp_cfg.svh"

module sys_regs (
  input  logic                                     adc_clk_i,
  input  logic                                     top_rst_i,
  sys_bus_if.slave                                 bus_i,
  input  rp_sample_pkg::adc_sample_t [`RP_CHN-1:0] adc_smp_i,
  output logic                                     loop_en_o,
  output rp_sample_pkg::dac_sample_t [`RP_CHN-1:0] dac_lvl_o
);

  rp_bus_pkg::bus_data_t [`RP_CHN-1:0] adc_ext;
  rp_bus_pkg::bus_data_t [`RP_CHN-1:0] dac_ext;

  // Sign extension to bus width
  always_comb begin
    for (int i = 0; i < `RP_CHN; i++) begin
      adc_ext[i] = {{(`RP_BUS_DW-`RP_ADC_DW){adc_smp_i[i][`RP_ADC_DW-1]}}, adc_smp_i[i]};
      dac_ext[i] = {{(`RP_BUS_DW-`RP_DAC_DW){dac_lvl_o[i][`RP_DAC_DW-1]}}, dac_lvl_o[i]};
    end
  end

  ////////////////////////////////////////
  // Writes
  ////////////////////////////////////////

  // ID and ADC words are read only
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      loop_en_o <= 1'b0;
      dac_lvl_o <= '0;
    end else if (bus_i.wen) begin
      case (bus_i.addr)
        `RP_REG_CTL:  loop_en_o    <= bus_i.wdata[0];
        `RP_REG_DAC0: dac_lvl_o[0] <= bus_i.wdata[`RP_DAC_DW-1:0];
        `RP_REG_DAC1: dac_lvl_o[1] <= bus_i.wdata[`RP_DAC_DW-1:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Reads and ack
  ////////////////////////////////////////

  // Ack one cycle after any strobe
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      bus_i.ack <= 1'b0;
    end else begin
      bus_i.ack <= bus_i.wen | bus_i.ren;
    end
  end

  // Unmapped words read as zero
  always_ff @(posedge adc_clk_i) begin
    case (bus_i.addr)
      `RP_REG_ID:   bus_i.rdata <= `RP_ID;
      `RP_REG_CTL:  bus_i.rdata <= {{(`RP_BUS_DW-1){1'b0}}, loop_en_o};
      `RP_REG_DAC0: bus_i.rdata <= dac_ext[0];
      `RP_REG_DAC1: bus_i.rdata <= dac_ext[1];
      `RP_REG_ADC0: bus_i.rdata <= adc_ext[0];
      `RP_REG_ADC1: bus_i.rdata <= adc_ext[1];
      default:      bus_i.rdata <= '0;
    endcase
  end

  // Master never issues read and write together
  a_no_rw : assert property (@(posedge adc_clk_i) disable iff (top_rst_i)
    !(bus_i.wen && bus_i.ren));

endmodule : sys_regs

`default_nettype wire

//--- verilog/pdm_regs.sv
/*
  Region 1 register: four PDM levels packed in one bus word
*/
`default_nettype none

`include "rp_cfg.svh"

module pdm_regs (
  input  logic                     adc_clk_i,
  input  logic                     top_rst_i,
  sys_bus_if.slave                 bus_i,
  output rp_sample_pkg::pdm_word_u pdm_cfg_o
);

  // Levels and ack
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      pdm_cfg_o <= '0;
      bus_i.ack <= 1'b0;
    end else begin
      bus_i.ack <= bus_i.wen | bus_i.ren;
      if (bus_i.wen && (bus_i.addr == `RP_REG_PDM)) begin
        pdm_cfg_o.raw <= bus_i.wdata;
      end
    end
  end

  // Readback through raw view, rest of region reads zero
  always_ff @(posedge adc_clk_i) begin
    bus_i.rdata <= (bus_i.addr == `RP_REG_PDM) ? pdm_cfg_o.raw : '0;
  end

endmodule : pdm_regs

`default_nettype wire

//--- verilog/pdm_modulator.sv
/*
  Four channel first order pulse density modulator
*/
`default_nettype none

`include "rp_cfg.svh"

module pdm_modulator (
  input  logic                     adc_clk_i,
  input  logic                     top_rst_i,
  input  rp_sample_pkg::pdm_word_u pdm_cfg_i,
  output logic [`RP_PDM_CHN-1:0]   pdm_o
);

  localparam logic [`RP_PDM_DW:0] RNG = `RP_PDM_RNG;

  // Accumulator stays below full scale
  rp_sample_pkg::pdm_level_t [`RP_PDM_CHN-1:0] acc;
  rp_sample_pkg::pdm_level_t [`RP_PDM_CHN-1:0] acc_nxt;
  logic [`RP_PDM_CHN-1:0][`RP_PDM_DW:0]        acc_sum;
  logic [`RP_PDM_CHN-1:0]                      hit;

  // Add level, wrap at full scale
  always_comb begin
    for (int i = 0; i < `RP_PDM_CHN; i++) begin
      acc_sum[i] = {1'b0, acc[i]} + {1'b0, pdm_cfg_i.lvl[i]};
      hit[i]     = (acc_sum[i] >= RNG);
      acc_nxt[i] = hit[i] ? `RP_PDM_DW'(acc_sum[i] - RNG) : acc_sum[i][`RP_PDM_DW-1:0];
    end
  end

  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      acc   <= '0;
      pdm_o <= '0;
    end else begin
      acc   <= acc_nxt;
      pdm_o <= hit;
    end
  end

endmodule : pdm_modulator

`default_nettype wire

//--- verilog/adc_frontend.sv
/*
  ADC capture: input register and conversion from
  negative slope offset code to two's complement
*/
`default_nettype none

`include "rp_cfg.svh"

module adc_frontend (
  input  logic                                     adc_clk_i,
  input  logic                                     top_rst_i,
  input  logic [`RP_CHN-1:0][`RP_ADC_DW-1:0]       adc_dat_i,
  output rp_sample_pkg::adc_sample_t [`RP_CHN-1:0] adc_smp_o
);

  // Keep sign bit, invert the magnitude bits
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      adc_smp_o <= '0;
    end else begin
      for (int i = 0; i < `RP_CHN; i++) begin
        adc_smp_o[i] <= {adc_dat_i[i][`RP_ADC_DW-1], ~adc_dat_i[i][`RP_ADC_DW-2:0]};
      end
    end
  end

endmodule : adc_frontend

`default_nettype wire

//--- verilog/dac_backend.sv
/*
  DAC output: per channel source select and code conversion,
  channel interleave on one bus and DAC reset
*/
`default_nettype none

`include "rp_cfg.svh"

module dac_backend (
  input  logic                                     adc_clk_i,
  input  logic                                     top_rst_i,
  input  logic                                     loop_en_i,
  input  rp_sample_pkg::dac_sample_t [`RP_CHN-1:0] dac_lvl_i,
  input  rp_sample_pkg::adc_sample_t [`RP_CHN-1:0] adc_smp_i,
  output logic [`RP_DAC_DW-1:0]                    dac_dat_o,
  output logic                                     dac_sel_o,
  output logic                                     dac_rst_o
);

  // Code for a zero sample
  localparam logic [`RP_DAC_DW-1:0] DAC_MID = {1'b0, {(`RP_DAC_DW-1){1'b1}}};

  rp_sample_pkg::dac_sample_t [`RP_CHN-1:0] src;
  logic [`RP_CHN-1:0][`RP_DAC_DW-1:0]       dac_raw;
  logic                                     rst_d;

  // Loopback takes the top ADC bits
  always_comb begin
    for (int i = 0; i < `RP_CHN; i++) begin
      src[i] = loop_en_i ? adc_smp_i[i][`RP_ADC_DW-1 -: `RP_DAC_DW] : dac_lvl_i[i];
    end
  end

  ////////////////////////////////////////
  // Channel registers and interleave
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      dac_raw   <= {`RP_CHN{DAC_MID}};
      dac_dat_o <= DAC_MID;
      dac_sel_o <= 1'b0;
    end else begin
      // Sign kept, rest inverted for the negative slope DAC
      for (int i = 0; i < `RP_CHN; i++) begin
        dac_raw[i] <= {src[i][`RP_DAC_DW-1], ~src[i][`RP_DAC_DW-2:0]};
      end
      // Next select low means channel 0
      dac_sel_o <= ~dac_sel_o;
      dac_dat_o <= dac_sel_o ? dac_raw[0] : dac_raw[1];
    end
  end

  // Reset held one full cycle past release
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      rst_d     <= 1'b1;
      dac_rst_o <= 1'b1;
    end else begin
      rst_d     <= 1'b0;
      dac_rst_o <= rst_d;
    end
  end

  // Select flips on every running cycle
  a_sel_toggle : assert property (@(posedge adc_clk_i) disable iff (top_rst_i || dac_rst_o)
    dac_sel_o != $past(dac_sel_o));

endmodule : dac_backend

`default_nettype wire

//--- verilog/rp_top.sv
/*
  Analog front end top: ADC capture, interleaved DAC output,
  PDM outputs and register access over the system bus
*/
`default_nettype none

`include "rp_cfg.svh"

module rp_top (
  input  logic                                adc_clk,
  input  logic                                top_rst,
  // ADC pins
  input  logic [`RP_CHN-1:0][`RP_ADC_DW-1:0]  adc_dat_i,
  // DAC pins
  output logic [`RP_DAC_DW-1:0]               dac_dat_o,
  output logic                                dac_sel_o,
  output logic                                dac_rst_o,
  // PDM pins
  output logic [`RP_PDM_CHN-1:0]              dac_pwm_o,
  // System bus
  input  logic [`RP_BUS_AW-1:0]               bus_addr_i,
  input  logic [`RP_BUS_DW-1:0]               bus_wdata_i,
  input  logic                                bus_wen_i,
  input  logic                                bus_ren_i,
  output logic [`RP_BUS_DW-1:0]               bus_rdata_o,
  output logic                                bus_ack_o
);

  ////////////////////////////////////////
  // Internal connections
  ////////////////////////////////////////

  rp_sample_pkg::adc_sample_t [`RP_CHN-1:0] adc_smp;
  rp_sample_pkg::dac_sample_t [`RP_CHN-1:0] dac_lvl;
  rp_sample_pkg::pdm_word_u                 pdm_cfg;
  logic                                     loop_en;

  // One bus per register region
  sys_bus_if sys_bus ();
  sys_bus_if pdm_bus ();

  ////////////////////////////////////////
  // Bus decoding and registers
  ////////////////////////////////////////

  sys_bus_decoder u_decoder (
    .adc_clk_i   (adc_clk),
    .top_rst_i   (top_rst),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_wen_i   (bus_wen_i),
    .bus_ren_i   (bus_ren_i),
    .bus_rdata_o (bus_rdata_o),
    .bus_ack_o   (bus_ack_o),
    .sys_bus_o   (sys_bus),
    .pdm_bus_o   (pdm_bus)
  );

  sys_regs u_sys_regs (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .bus_i     (sys_bus),
    .adc_smp_i (adc_smp),
    .loop_en_o (loop_en),
    .dac_lvl_o (dac_lvl)
  );

  pdm_regs u_pdm_regs (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .bus_i     (pdm_bus),
    .pdm_cfg_o (pdm_cfg)
  );

  ////////////////////////////////////////
  // Analog paths
  ////////////////////////////////////////

  pdm_modulator u_pdm (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .pdm_cfg_i (pdm_cfg),
    .pdm_o     (dac_pwm_o)
  );

  adc_frontend u_adc (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .adc_dat_i (adc_dat_i),
    .adc_smp_o (adc_smp)
  );

  dac_backend u_dac (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .loop_en_i (loop_en),
    .dac_lvl_i (dac_lvl),
    .adc_smp_i (adc_smp),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule : rp_top

`default_nettype wire

//--- bench/tb_top.sv
/*
  Directed testbench for the front end top: bus access, ADC
  conversion, DAC levels, loopback and PDM density
*/
`default_nettype none

`include "rp_cfg.svh"

module tb_top;

  timeunit 1ns;
  timeprecision 1ps;

  // Run needs well under 1200 cycles, the rest is margin
  localparam int TIMEOUT_CYC = 3000;
  localparam int ACK_WAIT    = 8;
  // Region 1 sits above address bit 7
  localparam logic [`RP_BUS_AW-1:0] PDM_ADDR = 8'h80 | `RP_REG_PDM;

  logic                               adc_clk;
  logic                               top_rst;
  logic [`RP_CHN-1:0][`RP_ADC_DW-1:0] adc_dat;
  logic [`RP_DAC_DW-1:0]              dac_dat;
  logic                               dac_sel;
  logic                               dac_rst;
  logic [`RP_PDM_CHN-1:0]             dac_pwm;
  logic [`RP_BUS_AW-1:0]              bus_addr;
  logic [`RP_BUS_DW-1:0]              bus_wdata;
  logic [`RP_BUS_DW-1:0]              bus_rdata;
  logic                               bus_wen;
  logic                               bus_ren;
  logic                               bus_ack;

  int          value_errors;
  int          proto_errors;
  int          cycles;
  int unsigned seed;
  // Levels last written, for loopback exit
  logic [`RP_DAC_DW-1:0] lvl0;
  logic [`RP_DAC_DW-1:0] lvl1;

  rp_top dut0 (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat),
    .dac_dat_o   (dac_dat),
    .dac_sel_o   (dac_sel),
    .dac_rst_o   (dac_rst),
    .dac_pwm_o   (dac_pwm),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_wen_i   (bus_wen),
    .bus_ren_i   (bus_ren),
    .bus_rdata_o (bus_rdata),
    .bus_ack_o   (bus_ack)
  );

  // 20 ns period
  always #10 adc_clk = ~adc_clk;

  // Watchdog
  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference conversions
  ////////////////////////////////////////

  // Offset code to two's complement, sign kept
  function automatic logic [`RP_ADC_DW-1:0] adc_conv(input logic [`RP_ADC_DW-1:0] raw);
    return {raw[`RP_ADC_DW-1], ~raw[`RP_ADC_DW-2:0]};
  endfunction

  function automatic logic [`RP_DAC_DW-1:0] dac_code(input logic [`RP_DAC_DW-1:0] v);
    return {v[`RP_DAC_DW-1], ~v[`RP_DAC_DW-2:0]};
  endfunction

  ////////////////////////////////////////
  // Bus and check helpers
  ////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    value_errors++;
    $display("ERROR at %0d ns: %s", $time, msg);
  endtask

  // One strobe, then wait for ack
  task automatic bus_access(input logic wr, input logic [`RP_BUS_AW-1:0] addr,
                            input logic [`RP_BUS_DW-1:0] wdata,
                            output logic [`RP_BUS_DW-1:0] rdata);
    int waited;
    waited = 1;
    @(negedge adc_clk);
    // Previous ack must be gone by now
    if (bus_ack !== 1'b0) begin
      proto_errors++;
      $display("Ack was already high before the strobe to address 0x%02h", addr);
    end
    bus_addr  = addr;
    bus_wdata = wdata;
    bus_wen   = wr;
    bus_ren   = !wr;
    @(negedge adc_clk);
    bus_wen = 1'b0;
    bus_ren = 1'b0;
    while (!bus_ack && waited < ACK_WAIT) begin
      @(negedge adc_clk);
      waited++;
    end
    rdata = bus_rdata;
    if (!bus_ack) begin
      proto_errors++;
      $display("Bus access to address 0x%02h was never acknowledged", addr);
    end else if (waited != 1) begin
      proto_errors++;
      $display("Ack for address 0x%02h came %0d cycles after the strobe", addr, waited);
    end
  endtask

  task automatic bus_write(input logic [`RP_BUS_AW-1:0] addr,
                           input logic [`RP_BUS_DW-1:0] wdata);
    logic [`RP_BUS_DW-1:0] unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic bus_read(input logic [`RP_BUS_AW-1:0] addr,
                          output logic [`RP_BUS_DW-1:0] rdata);
    bus_access(1'b0, addr, '0, rdata);
  endtask

  // Channel 0 while select low, channel 1 while high
  task automatic check_dac_stream(input logic [`RP_DAC_DW-1:0] exp0,
                                  input logic [`RP_DAC_DW-1:0] exp1,
                                  input int ncyc, input string tag);
    logic                  prev_sel;
    logic [`RP_DAC_DW-1:0] exp;
    prev_sel = dac_sel;
    repeat (ncyc) begin
      @(negedge adc_clk);
      exp = dac_sel ? exp1 : exp0;
      if (dac_dat !== exp) begin
        report_mismatch($sformatf("%s: dac_dat 0x%04h, expected 0x%04h (sel %b)",
                                  tag, dac_dat, exp, dac_sel));
      end
      if (dac_sel === prev_sel) begin
        report_mismatch($sformatf("%s: dac_sel stayed at %b", tag, dac_sel));
      end
      prev_sel = dac_sel;
    end
  endtask

  task automatic drive_adc(input logic [`RP_ADC_DW-1:0] raw0,
                           input logic [`RP_ADC_DW-1:0] raw1);
    @(negedge adc_clk);
    adc_dat[0] = raw0;
    adc_dat[1] = raw1;
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset();
    logic [`RP_BUS_DW-1:0] data;
    top_rst = 1'b1;
    repeat (2) @(negedge adc_clk);
    if (dac_rst !== 1'b1 || dac_sel !== 1'b0 || bus_ack !== 1'b0 || dac_pwm !== '0) begin
      report_mismatch($sformatf("in reset: rst %b sel %b ack %b pwm %b",
                                dac_rst, dac_sel, bus_ack, dac_pwm));
    end
    top_rst = 1'b0;
    // DAC reset stretched by one cycle
    @(negedge adc_clk);
    if (dac_rst !== 1'b1) report_mismatch("dac_rst low in first cycle after reset");
    @(negedge adc_clk);
    if (dac_rst !== 1'b0) report_mismatch("dac_rst still high two cycles after reset");
    check_dac_stream(dac_code('0), dac_code('0), 6, "reset");
    bus_read(`RP_REG_ID, data);
    if (data !== `RP_ID) report_mismatch($sformatf("ID read 0x%08h", data));
    // ID is read only
    bus_write(`RP_REG_ID, $urandom);
    bus_read(`RP_REG_ID, data);
    if (data !== `RP_ID) report_mismatch($sformatf("ID after write 0x%08h", data));
    bus_read(8'h10, data);
    if (data !== '0) report_mismatch($sformatf("unmapped 0x10 read 0x%08h", data));
    bus_read(PDM_ADDR + 8'd4, data);
    if (data !== '0) report_mismatch($sformatf("unmapped PDM word read 0x%08h", data));
  endtask

  task automatic test_adc();
    logic [`RP_ADC_DW-1:0] raw0;
    logic [`RP_ADC_DW-1:0] raw1;
    logic [`RP_ADC_DW-1:0] cv;
    logic [`RP_BUS_DW-1:0] data;
    repeat (4) begin
      raw0 = 16'($urandom);
      raw1 = 16'($urandom);
      drive_adc(raw0, raw1);
      repeat (2) @(negedge adc_clk);
      bus_read(`RP_REG_ADC0, data);
      cv = adc_conv(raw0);
      if (data !== {{(`RP_BUS_DW-`RP_ADC_DW){cv[`RP_ADC_DW-1]}}, cv}) begin
        report_mismatch($sformatf("ADC0 raw 0x%04h read 0x%08h", raw0, data));
      end
      bus_read(`RP_REG_ADC1, data);
      cv = adc_conv(raw1);
      if (data !== {{(`RP_BUS_DW-`RP_ADC_DW){cv[`RP_ADC_DW-1]}}, cv}) begin
        report_mismatch($sformatf("ADC1 raw 0x%04h read 0x%08h", raw1, data));
      end
    end
  endtask

  task automatic test_dac_levels();
    logic [`RP_BUS_DW-1:0] w0;
    logic [`RP_BUS_DW-1:0] w1;
    logic [`RP_BUS_DW-1:0] data;
    w0 = $urandom;
    w1 = $urandom;
    lvl0 = w0[`RP_DAC_DW-1:0];
    lvl1 = w1[`RP_DAC_DW-1:0];
    bus_write(`RP_REG_DAC0, w0);
    bus_write(`RP_REG_DAC1, w1);
    // Readback keeps 14 bits, sign extended
    bus_read(`RP_REG_DAC0, data);
    if (data !== {{(`RP_BUS_DW-`RP_DAC_DW){lvl0[`RP_DAC_DW-1]}}, lvl0}) begin
      report_mismatch($sformatf("DAC0 level read 0x%08h", data));
    end
    bus_read(`RP_REG_DAC1, data);
    if (data !== {{(`RP_BUS_DW-`RP_DAC_DW){lvl1[`RP_DAC_DW-1]}}, lvl1}) begin
      report_mismatch($sformatf("DAC1 level read 0x%08h", data));
    end
    repeat (3) @(negedge adc_clk);
    check_dac_stream(dac_code(lvl0), dac_code(lvl1), 10, "levels");
  endtask

  task automatic test_loopback();
    logic [`RP_ADC_DW-1:0] raw0;
    logic [`RP_ADC_DW-1:0] raw1;
    logic [`RP_ADC_DW-1:0] cv0;
    logic [`RP_ADC_DW-1:0] cv1;
    logic [`RP_BUS_DW-1:0] data;
    raw0 = 16'($urandom);
    raw1 = 16'($urandom);
    cv0  = adc_conv(raw0);
    cv1  = adc_conv(raw1);
    drive_adc(raw0, raw1);
    bus_write(`RP_REG_CTL, 32'd1);
    bus_read(`RP_REG_CTL, data);
    if (data !== 32'd1) report_mismatch($sformatf("CTL read 0x%08h after set", data));
    repeat (3) @(negedge adc_clk);
    // Top 14 bits of each sample
    check_dac_stream(dac_code(cv0[`RP_ADC_DW-1 -: `RP_DAC_DW]),
                     dac_code(cv1[`RP_ADC_DW-1 -: `RP_DAC_DW]), 10, "loopback");
    bus_write(`RP_REG_CTL, 32'd0);
    repeat (3) @(negedge adc_clk);
    check_dac_stream(dac_code(lvl0), dac_code(lvl1), 10, "loopback off");
  endtask

  task automatic test_pdm();
    logic [`RP_BUS_DW-1:0] word;
    logic [`RP_BUS_DW-1:0] data;
    int                    ones [`RP_PDM_CHN];
    word = $urandom;
    bus_write(PDM_ADDR, word);
    bus_read(PDM_ADDR, data);
    if (data !== word) report_mismatch($sformatf("PDM word read 0x%08h, wrote 0x%08h",
                                                 data, word));
    repeat (4) @(negedge adc_clk);
    for (int i = 0; i < `RP_PDM_CHN; i++) ones[i] = 0;
    // One full range window gives exactly level ones
    repeat (`RP_PDM_RNG) begin
      @(negedge adc_clk);
      for (int i = 0; i < `RP_PDM_CHN; i++) begin
        if (dac_pwm[i]) ones[i]++;
      end
    end
    for (int i = 0; i < `RP_PDM_CHN; i++) begin
      if (ones[i] != int'(word[`RP_PDM_DW*i +: `RP_PDM_DW])) begin
        report_mismatch($sformatf("PDM ch%0d gave %0d ones, level %0d",
                                  i, ones[i], word[`RP_PDM_DW*i +: `RP_PDM_DW]));
      end
    end
  endtask

  ////////////////////////////////////////
  // Sequence and verdict
  ////////////////////////////////////////

  initial begin
    // Fixed seed for repeatable data
    seed      = $urandom(22);
    adc_clk   = 1'b0;
    top_rst   = 1'b1;
    adc_dat   = '0;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    lvl0      = '0;
    lvl1      = '0;
    test_reset();
    test_adc();
    test_dac_levels();
    test_loopback();
    test_pdm();
    repeat (2) @(negedge adc_clk);
    $display("Errors: %0d value mismatches, %0d bus protocol failures",
             value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : tb_top

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/rp_bus_pkg.sv
verilog/rp_sample_pkg.sv
verilog/sys_bus_if.sv
verilog/sys_bus_decoder.sv
verilog/sys_regs.sv
verilog/pdm_regs.sv
verilog/pdm_modulator.sv
verilog/adc_frontend.sv
verilog/dac_backend.sv
verilog/rp_top.sv
bench/tb_top.sv

//--- Makefile
# Verilator flow for the analog front end
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= files.f
TOP       ?= tb_top
LINT_TOP  ?= rp_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
